//--- logic/busPkg.sv
package busPkg;

    // wishbone byte address width
    localparam int ADR_W = 32;
    // data width of both bus ports
    localparam int DAT_W = 64;
    // one select bit per data byte
    localparam int SEL_W = DAT_W / 8;

    // backing RAM depth in 64-bit words
    localparam int MEM_WORDS = 256;
    // word index into the RAM starts above the byte offset
    localparam int MEM_ADR_LSB = 3;
    // so the RAM sees address bits 10 to 3
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // wait cycles between seeing a strobe and acknowledging it
    localparam int MEM_WAIT = 2;
    // width of the wait-state counter
    localparam int MEM_WAIT_W = $clog2(MEM_WAIT + 1);

endpackage

//--- logic/cachePkg.sv
package cachePkg;

    import busPkg::*;

    // four sets, one 64-bit word per line
    localparam int NUM_SETS = 4;
    localparam int IDX_W = $clog2(NUM_SETS);

    // address layout: [31:5] tag, [4:3] index, [2:0] byte offset
    localparam int IDX_LSB = 3;
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam int TAG_W = ADR_W - TAG_LSB;

    // two-way set associative
    // the single victim bit per set relies on this being 2
    localparam int NUM_WAYS = 2;

    // width of the read hit and miss counters
    localparam int CNT_W = 16;

endpackage

//--- logic/cacheArray.sv
module cacheArray
    import busPkg::*, cachePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    // combinational lookup port
    input  logic [ADR_W-1:0] lookupAdr,
    output logic             hit,
    output logic [DAT_W-1:0] hitData,
    // refill of the victim way after a read miss
    input  logic             refillEn,
    input  logic [ADR_W-1:0] refillAdr,
    input  logic [DAT_W-1:0] refillData,
    // write-through update, only lands on a hit
    input  logic             writeEn,
    input  logic [ADR_W-1:0] writeAdr,
    input  logic [DAT_W-1:0] writeData,
    input  logic [SEL_W-1:0] writeSel
);

    // per-way storage, indexed [way][set]
    logic [TAG_W-1:0]    tagMem  [NUM_WAYS][NUM_SETS];
    logic [DAT_W-1:0]    dataMem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid   [NUM_WAYS];

    // one bit per set, names the way the next refill goes to
    logic [NUM_SETS-1:0] victim;

    // address fields of the three ports
    logic [IDX_W-1:0] lookIdx;
    logic [TAG_W-1:0] lookTag;
    logic [IDX_W-1:0] refillIdx;
    logic [TAG_W-1:0] refillTag;
    logic [IDX_W-1:0] writeIdx;
    logic [TAG_W-1:0] writeTag;

    // tag match per way
    logic [NUM_WAYS-1:0] lookHit;
    logic [NUM_WAYS-1:0] writeHit;

    // way chosen for the current refill
    logic refillWay;

    assign lookIdx   = lookupAdr[IDX_LSB +: IDX_W];
    assign lookTag   = lookupAdr[TAG_LSB +: TAG_W];
    assign refillIdx = refillAdr[IDX_LSB +: IDX_W];
    assign refillTag = refillAdr[TAG_LSB +: TAG_W];
    assign writeIdx  = writeAdr[IDX_LSB +: IDX_W];
    assign writeTag  = writeAdr[TAG_LSB +: TAG_W];

    assign refillWay = victim[refillIdx];

    // compare both ways of the indexed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookHit[w]  = valid[w][lookIdx] && (tagMem[w][lookIdx] == lookTag);
            writeHit[w] = valid[w][writeIdx] && (tagMem[w][writeIdx] == writeTag);
        end
    end

    assign hit = |lookHit;

    // matching way's word, way 0 when nothing matches
    always_comb begin
        hitData = dataMem[0][lookIdx];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (lookHit[w]) begin
                hitData = dataMem[w][lookIdx];
            end
        end
    end

    // valid and victim state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid[w] <= '0;
            end
            victim <= '0;
        end else if (refillEn) begin
            valid[refillWay][refillIdx] <= 1'b1;
            // alternate ways on every refill of this set
            victim[refillIdx] <= ~victim[refillIdx];
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (refillEn) begin
            tagMem[refillWay][refillIdx]  <= refillTag;
            dataMem[refillWay][refillIdx] <= refillData;
        end
        // masked update of a present copy, victim bit untouched
        if (writeEn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (writeHit[w] && writeSel[b]) begin
                        dataMem[w][writeIdx][8*b +: 8] <= writeData[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- logic/cacheController.sv
module cacheController
    import busPkg::*, cachePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    // cpu side, wishbone classic slave
    input  logic             cpuCyc,
    input  logic             cpuStb,
    input  logic             cpuWe,
    input  logic [ADR_W-1:0] cpuAdr,
    input  logic [DAT_W-1:0] cpuDatW,
    input  logic [SEL_W-1:0] cpuSel,
    output logic             cpuAck,
    output logic [DAT_W-1:0] cpuDatR,
    // memory side, wishbone classic master
    output logic             memCyc,
    output logic             memStb,
    output logic             memWe,
    output logic [ADR_W-1:0] memAdr,
    output logic [DAT_W-1:0] memDatW,
    output logic [SEL_W-1:0] memSel,
    input  logic             memAck,
    input  logic [DAT_W-1:0] memDatR,
    // cache array port
    output logic [ADR_W-1:0] lookupAdr,
    input  logic             hit,
    input  logic [DAT_W-1:0] hitData,
    output logic             refillEn,
    output logic [ADR_W-1:0] refillAdr,
    output logic [DAT_W-1:0] refillData,
    output logic             writeEn,
    output logic [ADR_W-1:0] writeAdr,
    output logic [DAT_W-1:0] writeData,
    output logic [SEL_W-1:0] writeSel,
    // performance counters
    output logic [CNT_W-1:0] hitCount,
    output logic [CNT_W-1:0] missCount
);

    typedef enum logic [1:0] {
        stateIdle,
        stateMem,
        stateResp
    } stateT;

    stateT state;

    // request accepted this edge
    logic newReq;

    // latched cpu request, held for the whole memory cycle
    logic             reqWe;
    logic [ADR_W-1:0] reqAdr;
    logic [DAT_W-1:0] reqDatW;
    logic [SEL_W-1:0] reqSel;

    assign newReq = (state == stateIdle) && cpuCyc && cpuStb;

    // lookup runs straight off the cpu address while idle
    assign lookupAdr = cpuAdr;

    // memory request comes from the latched copy, stable through wait states
    assign memWe   = reqWe;
    assign memAdr  = reqAdr;
    assign memDatW = reqDatW;
    assign memSel  = reqSel;

    // refill uses the word already captured for the cpu response
    assign refillAdr  = reqAdr;
    assign refillData = cpuDatR;

    // write update mirrors what went to memory
    assign writeAdr  = reqAdr;
    assign writeData = reqDatW;
    assign writeSel  = reqSel;

    // control FSM and counters
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stateIdle;
            cpuAck    <= 1'b0;
            memCyc    <= 1'b0;
            memStb    <= 1'b0;
            refillEn  <= 1'b0;
            writeEn   <= 1'b0;
            hitCount  <= '0;
            missCount <= '0;
        end else begin
            // single-cycle pulses by default
            cpuAck   <= 1'b0;
            refillEn <= 1'b0;
            writeEn  <= 1'b0;
            case (state)
                stateIdle: begin
                    if (newReq) begin
                        if (!cpuWe && hit) begin
                            // read hit answers next cycle
                            cpuAck   <= 1'b1;
                            hitCount <= hitCount + 1'b1;
                            state    <= stateResp;
                        end else begin
                            // read miss or write-through goes to memory
                            memCyc <= 1'b1;
                            memStb <= 1'b1;
                            state  <= stateMem;
                            if (!cpuWe) begin
                                missCount <= missCount + 1'b1;
                            end
                        end
                    end
                end
                stateMem: begin
                    if (memAck) begin
                        memCyc   <= 1'b0;
                        memStb   <= 1'b0;
                        cpuAck   <= 1'b1;
                        // array update lands on the cpu ack edge
                        refillEn <= !reqWe;
                        writeEn  <= reqWe;
                        state    <= stateResp;
                    end
                end
                stateResp: begin
                    // ack cycle, master moves on at this edge
                    state <= stateIdle;
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (newReq) begin
            reqWe   <= cpuWe;
            reqAdr  <= cpuAdr;
            reqDatW <= cpuDatW;
            reqSel  <= cpuSel;
        end
        if (newReq && hit) begin
            cpuDatR <= hitData;
        end else if ((state == stateMem) && memAck) begin
            cpuDatR <= memDatR;
        end
    end

endmodule

//--- logic/wbMemory.sv
module wbMemory
    import busPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  logic [DAT_W-1:0] datW,
    input  logic [SEL_W-1:0] sel,
    output logic             ack,
    output logic [DAT_W-1:0] datR
);

    logic [DAT_W-1:0] ram [MEM_WORDS];

    // strobe cycles seen so far in this access
    logic [MEM_WAIT_W-1:0] waitCnt;

    // word index from address bits 10 to 3
    logic [MEM_IDX_W-1:0] wordIdx;

    // last wait state done, acknowledge at this edge
    logic ackNow;

    assign wordIdx = adr[MEM_ADR_LSB +: MEM_IDX_W];
    assign ackNow  = cyc && stb && !ack && (waitCnt == MEM_WAIT_W'(MEM_WAIT));

    // wait counter and ack pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            waitCnt <= '0;
        end else if (ack) begin
            // one-cycle ack, then ready for the next strobe
            ack     <= 1'b0;
            waitCnt <= '0;
        end else if (ackNow) begin
            ack <= 1'b1;
        end else if (cyc && stb) begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    // RAM access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (ackNow) begin
            if (we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) begin
                        ram[wordIdx][8*b +: 8] <= datW[8*b +: 8];
                    end
                end
            end else begin
                datR <= ram[wordIdx];
            end
        end
    end

endmodule

//--- logic/dataCacheTop.sv
module dataCacheTop
    import busPkg::*, cachePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             cpuCyc,
    input  logic             cpuStb,
    input  logic             cpuWe,
    input  logic [ADR_W-1:0] cpuAdr,
    input  logic [DAT_W-1:0] cpuDatW,
    input  logic [SEL_W-1:0] cpuSel,
    output logic             cpuAck,
    output logic [DAT_W-1:0] cpuDatR,
    output logic [CNT_W-1:0] hitCount,
    output logic [CNT_W-1:0] missCount
);

    // controller to backing memory
    logic             memCyc;
    logic             memStb;
    logic             memWe;
    logic [ADR_W-1:0] memAdr;
    logic [DAT_W-1:0] memDatW;
    logic [SEL_W-1:0] memSel;
    logic             memAck;
    logic [DAT_W-1:0] memDatR;

    // controller to cache storage
    logic [ADR_W-1:0] lookupAdr;
    logic             hit;
    logic [DAT_W-1:0] hitData;
    logic             refillEn;
    logic [ADR_W-1:0] refillAdr;
    logic [DAT_W-1:0] refillData;
    logic             writeEn;
    logic [ADR_W-1:0] writeAdr;
    logic [DAT_W-1:0] writeData;
    logic [SEL_W-1:0] writeSel;

    // sequences cpu requests against the array and memory
    cacheController ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpuCyc     (cpuCyc),
        .cpuStb     (cpuStb),
        .cpuWe      (cpuWe),
        .cpuAdr     (cpuAdr),
        .cpuDatW    (cpuDatW),
        .cpuSel     (cpuSel),
        .cpuAck     (cpuAck),
        .cpuDatR    (cpuDatR),
        .memCyc     (memCyc),
        .memStb     (memStb),
        .memWe      (memWe),
        .memAdr     (memAdr),
        .memDatW    (memDatW),
        .memSel     (memSel),
        .memAck     (memAck),
        .memDatR    (memDatR),
        .lookupAdr  (lookupAdr),
        .hit        (hit),
        .hitData    (hitData),
        .refillEn   (refillEn),
        .refillAdr  (refillAdr),
        .refillData (refillData),
        .writeEn    (writeEn),
        .writeAdr   (writeAdr),
        .writeData  (writeData),
        .writeSel   (writeSel),
        .hitCount   (hitCount),
        .missCount  (missCount)
    );

    // two-way tag and data storage
    cacheArray store (
        .clk        (clk),
        .rst        (rst),
        .lookupAdr  (lookupAdr),
        .hit        (hit),
        .hitData    (hitData),
        .refillEn   (refillEn),
        .refillAdr  (refillAdr),
        .refillData (refillData),
        .writeEn    (writeEn),
        .writeAdr   (writeAdr),
        .writeData  (writeData),
        .writeSel   (writeSel)
    );

    // backing RAM with fixed wait states
    wbMemory mem (
        .clk  (clk),
        .rst  (rst),
        .cyc  (memCyc),
        .stb  (memStb),
        .we   (memWe),
        .adr  (memAdr),
        .datW (memDatW),
        .sel  (memSel),
        .ack  (memAck),
        .datR (memDatR)
    );

endmodule

//--- tb/dataCacheBus_sva.sv
module dataCacheBusSva (
    input logic clk,
    input logic rst,
    input logic cpuCyc,
    input logic cpuStb,
    input logic cpuAck,
    input logic memStb,
    input logic memAck
);

    // slave acks only an open request
    cpuAckInCycle: assert property (@(posedge clk) disable iff (rst)
        cpuAck |-> (cpuCyc && cpuStb))
        else $error("cpuAck raised without cpuCyc and cpuStb");

    // ack is a single-cycle pulse
    cpuAckPulse: assert property (@(posedge clk) disable iff (rst)
        cpuAck |=> !cpuAck)
        else $error("cpuAck high for two cycles running");

    // master holds its memory request through wait states
    memStbHeld: assert property (@(posedge clk) disable iff (rst)
        (memStb && !memAck) |=> memStb)
        else $error("memStb dropped before memAck");

    memAckWithStb: assert property (@(posedge clk) disable iff (rst)
        memAck |-> memStb)
        else $error("memAck raised without memStb");

endmodule

bind dataCacheTop dataCacheBusSva busChecks (
    .clk    (clk),
    .rst    (rst),
    .cpuCyc (cpuCyc),
    .cpuStb (cpuStb),
    .cpuAck (cpuAck),
    .memStb (memStb),
    .memAck (memAck)
);

//--- tb/dataCacheTb.sv
module dataCacheTb
    import busPkg::*, cachePkg::*;
();

    // 2 + 3 + 12 + 8 + 16 + 60 bus transactions over all tests
    localparam int TXN_COUNT = 101;
    // worst case of MEM_WAIT + 4 edges per transaction with a factor 2 of margin
    localparam int TIMEOUT_CYCLES = TXN_COUNT * (MEM_WAIT + 4) * 2;
    localparam logic [15:0] LFSR_SEED = 16'd75;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic             clk;
    logic             rst;
    logic             cpuCyc;
    logic             cpuStb;
    logic             cpuWe;
    logic [ADR_W-1:0] cpuAdr;
    logic [DAT_W-1:0] cpuDatW;
    logic [SEL_W-1:0] cpuSel;
    logic             cpuAck;
    logic [DAT_W-1:0] cpuDatR;
    logic [CNT_W-1:0] hitCount;
    logic [CNT_W-1:0] missCount;

    // memory contents keyed by word index
    logic [DAT_W-1:0] memModel [int];
    // shadow of cache tags, valid and victim bits
    logic [TAG_W-1:0] tagModel [NUM_WAYS][NUM_SETS];
    logic             validModel [NUM_WAYS][NUM_SETS];
    logic             victimModel [NUM_SETS];
    int               hitModel;
    int               missModel;

    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          cycleCount = 0;
    logic [15:0] lfsrState;

    dataCacheTop i_dut (
        .clk       (clk),
        .rst       (rst),
        .cpuCyc    (cpuCyc),
        .cpuStb    (cpuStb),
        .cpuWe     (cpuWe),
        .cpuAdr    (cpuAdr),
        .cpuDatW   (cpuDatW),
        .cpuSel    (cpuSel),
        .cpuAck    (cpuAck),
        .cpuDatR   (cpuDatR),
        .hitCount  (hitCount),
        .missCount (missCount)
    );

    always #4 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // galois step with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic randomBits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[62:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("Mismatch at time %0t: %s", $time, msg);
    endtask

    // hit or miss prediction where a miss refills the victim way and flips its bit
    task automatic modelRead(input logic [ADR_W-1:0] adr, output logic expHit);
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic             way;
        idx = adr[IDX_LSB +: IDX_W];
        tag = adr[TAG_LSB +: TAG_W];
        expHit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (validModel[w][idx] && tagModel[w][idx] == tag) begin
                expHit = 1'b1;
            end
        end
        if (expHit) begin
            hitModel++;
        end else begin
            missModel++;
            way = victimModel[idx];
            tagModel[way][idx] = tag;
            validModel[way][idx] = 1'b1;
            victimModel[idx] = ~victimModel[idx];
        end
    endtask

    // write-through keeps any cached copy equal to memory
    task automatic modelWrite(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] data,
                              input logic [SEL_W-1:0] sel);
        int               word;
        logic [DAT_W-1:0] merged;
        word = int'(adr[MEM_ADR_LSB +: MEM_IDX_W]);
        merged = memModel.exists(word) ? memModel[word] : 'x;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        memModel[word] = merged;
    endtask

    // one read cycle whose cycles output counts edges from driving the strobe to seeing ack
    task automatic wbRead(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] data,
                          output int cycles);
        @(posedge clk);
        cpuCyc <= 1'b1;
        cpuStb <= 1'b1;
        cpuWe  <= 1'b0;
        cpuAdr <= adr;
        cpuSel <= '1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cpuAck !== 1'b1);
        data = cpuDatR;
        cpuCyc <= 1'b0;
        cpuStb <= 1'b0;
    endtask

    task automatic wbWrite(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] data,
                           input logic [SEL_W-1:0] sel);
        @(posedge clk);
        cpuCyc  <= 1'b1;
        cpuStb  <= 1'b1;
        cpuWe   <= 1'b1;
        cpuAdr  <= adr;
        cpuDatW <= data;
        cpuSel  <= sel;
        do begin
            @(posedge clk);
        end while (cpuAck !== 1'b1);
        cpuCyc <= 1'b0;
        cpuStb <= 1'b0;
        cpuWe  <= 1'b0;
    endtask

    task automatic checkCounters(input string what);
        checkCount++;
        if (hitCount !== CNT_W'(hitModel) || missCount !== CNT_W'(missModel)) begin
            reportMismatch($sformatf("%s: hitCount %0d missCount %0d, expected %0d and %0d",
                                     what, hitCount, missCount, hitModel, missModel));
        end
    endtask

    task automatic checkRead(input logic [ADR_W-1:0] adr);
        logic             expHit;
        logic [DAT_W-1:0] expData;
        logic [DAT_W-1:0] data;
        int               cycles;
        expData = memModel[int'(adr[MEM_ADR_LSB +: MEM_IDX_W])];
        modelRead(adr, expHit);
        wbRead(adr, data, cycles);
        checkCount++;
        if (data !== expData) begin
            reportMismatch($sformatf("read %h returned %h, expected %h", adr, data, expData));
        end
        // a hit acks on the edge right after the one that sampled the strobe
        if (expHit && cycles != 2) begin
            reportMismatch($sformatf("read hit %h acked after %0d edges", adr, cycles));
        end
        if (!expHit && cycles <= 2) begin
            reportMismatch($sformatf("read miss %h acked after %0d edges", adr, cycles));
        end
        checkCounters($sformatf("after read %h", adr));
    endtask

    task automatic checkWrite(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] data,
                              input logic [SEL_W-1:0] sel);
        wbWrite(adr, data, sel);
        modelWrite(adr, data, sel);
        // writes are not counted
        checkCounters($sformatf("after write %h", adr));
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - startErrors);
        end
    endtask

    // counters start at zero and the first read of set 0 misses
    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        checkCounters("after reset");
        checkWrite(32'h0000_0100, 64'h0123_4567_89AB_CDEF, 8'hFF);
        checkRead(32'h0000_0100);
        finishTest("reset state", startErrors);
    endtask

    // miss then hit on the same word as set 0 takes its second refill
    task automatic testWriteRead();
        int startErrors;
        startErrors = errorCount;
        checkWrite(32'h0000_0200, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF);
        checkRead(32'h0000_0200);
        checkRead(32'h0000_0200);
        finishTest("write-through then read", startErrors);
    endtask

    // 0x110, 0x210 and 0x310 share set 2 while 0x118 sits alone in set 3
    task automatic testByteMask();
        int startErrors;
        startErrors = errorCount;
        checkWrite(32'h0000_0110, 64'h1111_2222_3333_4444, 8'hFF);
        checkWrite(32'h0000_0210, 64'h5555_6666_7777_8888, 8'hFF);
        checkWrite(32'h0000_0310, 64'h9999_AAAA_BBBB_CCCC, 8'hFF);
        checkRead(32'h0000_0110);
        // masked update of the cached copy followed by a hit
        checkWrite(32'h0000_0110, 64'hFFEE_DDCC_BBAA_9988, 8'b0101_0011);
        checkRead(32'h0000_0110);
        // two more refills of set 2 push 0x110 out so its reread comes from memory
        checkRead(32'h0000_0210);
        checkRead(32'h0000_0310);
        checkRead(32'h0000_0110);
        // masked write to an uncached word must not allocate
        checkWrite(32'h0000_0118, 64'h0F0F_0F0F_0F0F_0F0F, 8'hFF);
        checkWrite(32'h0000_0118, 64'hA5A5_A5A5_5A5A_5A5A, 8'hF0);
        checkRead(32'h0000_0118);
        finishTest("byte masks", startErrors);
    endtask

    // set 1 is untouched so 0x508 fills way 0, 0x608 way 1 and 0x708 lands over 0x508
    task automatic testReplacement();
        int startErrors;
        startErrors = errorCount;
        checkWrite(32'h0000_0508, 64'h0000_0000_0000_0508, 8'hFF);
        checkWrite(32'h0000_0608, 64'h0000_0000_0000_0608, 8'hFF);
        checkWrite(32'h0000_0708, 64'h0000_0000_0000_0708, 8'hFF);
        checkRead(32'h0000_0508);
        checkRead(32'h0000_0608);
        checkRead(32'h0000_0708);
        // 0x608 still sits in way 1
        checkRead(32'h0000_0608);
        // 0x508 was evicted and now refills way 1
        checkRead(32'h0000_0508);
        finishTest("replacement", startErrors);
    endtask

    // 16 words from 0x400 up with four tags in each set
    task automatic testRandom();
        int               startErrors;
        logic [63:0]      isWrite;
        logic [63:0]      pick;
        logic [63:0]      sel;
        logic [63:0]      data;
        logic [ADR_W-1:0] adr;
        startErrors = errorCount;
        for (int i = 0; i < 16; i++) begin
            randomBits(64, data);
            adr = 32'h0000_0400 + 32'(i * 8);
            checkWrite(adr, data, '1);
        end
        for (int n = 0; n < 60; n++) begin
            randomBits(1, isWrite);
            randomBits(4, pick);
            adr = 32'h0000_0400 + {25'd0, pick[3:0], 3'b000};
            if (isWrite[0]) begin
                randomBits(8, sel);
                randomBits(64, data);
                checkWrite(adr, data, sel[SEL_W-1:0]);
            end else begin
                checkRead(adr);
            end
        end
        finishTest("random traffic", startErrors);
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        cpuCyc  = 1'b0;
        cpuStb  = 1'b0;
        cpuWe   = 1'b0;
        cpuAdr  = '0;
        cpuDatW = '0;
        cpuSel  = '0;
        lfsrState = LFSR_SEED;
        hitModel  = 0;
        missModel = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            victimModel[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                validModel[w][s] = 1'b0;
                tagModel[w][s] = '0;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testWriteRead();
        testByteMask();
        testReplacement();
        testRandom();
        $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- files.f
logic/busPkg.sv
logic/cachePkg.sv
logic/cacheArray.sv
logic/cacheController.sv
logic/wbMemory.sv
logic/dataCacheTop.sv
tb/dataCacheBus_sva.sv
tb/dataCacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module dataCacheTb \
    -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -qx "Finished with no errors" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
